/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = map_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_LINE = ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -Fxq "$(PASS_LINE)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
+incdir+hdl
hdl/map_pkg.sv
hdl/box_if.sv
hdl/brick_store.sv
hdl/bullet_hit.sv
hdl/motion_block.sv
hdl/pixel_map.sv
hdl/map_top.sv
testbench/map_chk.sv
testbench/map_tb.sv

/* hdl/box_if.sv */
`timescale 1ns/100ps

// edges of a moving object on screen
interface box_if import map_pkg::*; ();

    // left and right x, top and bottom y
    coord_t l;
    coord_t r;
    coord_t t;
    coord_t b;

    // producer side
    modport src (output l, r, t, b);

    // consumer side
    modport dst (input l, r, t, b);

endinterface : box_if

/* hdl/brick_store.sv */
`timescale 1ns/100ps
`include "map_consts.svh"

module brick_store import map_pkg::*; (
    input  logic        clk_50MHz,
    input  logic        reset,
    input  logic        map_index,
    input  brick_mask_t clear_mask,
    output brick_tab_t  bricks
);

    // bricks around the base, six short columns
    localparam int num_base = 20;
    localparam coord_t base_x [num_base] = '{
        288, 288, 288,
        304, 304, 304, 304,
        320, 320, 320,
        336, 336, 336,
        352, 352, 352, 352,
        368, 368, 368
    };
    localparam coord_t base_y [num_base] = '{
        432, 416, 400,
        432, 416, 400, 384,
        400, 384, 368,
        400, 384, 368,
        432, 416, 400, 384,
        432, 416, 400
    };

    // field columns of map 0, each filled top down
    localparam int     col_len     = 21;
    localparam coord_t col_top     = 80;
    localparam coord_t col_x [5]   = '{96, 240, 544, 112, 256};

    // registered map select, a mismatch triggers a reload
    logic map_q;

    // map 0, base first and then the field columns
    function automatic brick_tab_t build_map0();
        brick_tab_t tab;
        int         k;
        for (int i = 0; i < `NUM_BRICKS; i++) begin
            if (i < num_base) begin
                tab[i].x = base_x[i];
                tab[i].y = base_y[i];
            end else begin
                k = i - num_base;
                tab[i].x = col_x[k / col_len];
                tab[i].y = col_top + coord_t'((k % col_len) * `STEP);
            end
            tab[i].valid = 1'b1;
        end
        return tab;
    endfunction

    // map 1, rows left to right with wrap
    function automatic brick_tab_t build_map1();
        brick_tab_t tab;
        tab[0].x     = `MAP1_X0;
        tab[0].y     = `MAP1_Y0;
        tab[0].valid = 1'b1;
        for (int i = 1; i < `NUM_BRICKS; i++) begin
            if (tab[i-1].x > `ROW_WRAP) begin
                tab[i].x = `MAP1_X0;
                tab[i].y = tab[i-1].y + `ROW_PITCH;
            end else begin
                tab[i].x = tab[i-1].x + `STEP;
                tab[i].y = tab[i-1].y;
            end
            tab[i].valid = 1'b1;
        end
        return tab;
    endfunction

    // layout for a given select
    function automatic brick_tab_t load_map(input logic sel);
        return sel ? build_map1() : build_map0();
    endfunction

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            // table tracks the selected layout during reset
            map_q  <= map_index;
            bricks <= load_map(map_index);
        end else begin
            map_q <= map_index;
            if (map_q != map_index) begin
                // reload wins over a clear on the same edge
                bricks <= load_map(map_index);
            end else begin
                for (int i = 0; i < `NUM_BRICKS; i++) begin
                    if (clear_mask[i])
                        bricks[i].valid <= 1'b0;
                end
            end
        end
    end

endmodule : brick_store

/* hdl/bullet_hit.sv */
`timescale 1ns/100ps
`include "map_consts.svh"

module bullet_hit import map_pkg::*; (
    input  logic        clk_50MHz,
    input  logic        reset,
    input  logic        refresh_tick,
    input  brick_tab_t  bricks,
    box_if.dst          bullet,
    input  coord_t      x_bullet_enemy,
    input  coord_t      y_bullet_enemy,
    output brick_mask_t clear_mask,
    output logic        hit,
    output logic        hit_by_enemy
);

    // per brick overlap, only live bricks count
    brick_mask_t mask_player;
    brick_mask_t mask_enemy;

    always_comb begin
        for (int i = 0; i < `NUM_BRICKS; i++) begin
            // player bullet box against brick box
            mask_player[i] = bricks[i].valid
                && (bullet.t < bricks[i].y + `BRICK_SPAN)
                && (bullet.b > bricks[i].y)
                && (bullet.l < bricks[i].x + `BRICK_SPAN)
                && (bullet.r > bricks[i].x);
            // enemy bullet as a point plus its span
            mask_enemy[i] = bricks[i].valid
                && (y_bullet_enemy < bricks[i].y + `BRICK_SPAN)
                && (y_bullet_enemy + `SHOT_SPAN > bricks[i].y)
                && (x_bullet_enemy < bricks[i].x + `BRICK_SPAN)
                && (x_bullet_enemy + `SHOT_SPAN > bricks[i].x);
        end
    end

    // bricks only go away on a refresh tick
    assign clear_mask = refresh_tick ? (mask_player | mask_enemy) : '0;

    // one cycle pulse per shooter after the tick
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            hit          <= 1'b0;
            hit_by_enemy <= 1'b0;
        end else begin
            hit          <= refresh_tick && (|mask_player);
            hit_by_enemy <= refresh_tick && (|mask_enemy);
        end
    end

endmodule : bullet_hit

/* hdl/map_consts.svh */
`ifndef MAP_CONSTS_SVH
`define MAP_CONSTS_SVH

// brick table size
`define NUM_BRICKS 32

// brick geometry, top-left corner plus span gives far edge
`define BRICK_SPAN 15
`define STEP       16

// tank blocking distances
`define STOP_GAP   2
`define STOP_REACH 32

// enemy bullet is a small square from its anchor point
`define SHOT_SPAN  3

// inner edges of the border wall
`define WALL_L 31
`define WALL_R 608
`define WALL_T 31
`define WALL_B 448

// map 1 row fill
`define ROW_WRAP  600
`define ROW_PITCH 64
`define MAP1_X0   32
`define MAP1_Y0   256

`endif

/* hdl/map_pkg.sv */
`include "map_consts.svh"

package map_pkg;

    // screen coordinate, 640x480 fits in 10 bits
    typedef logic [9:0] coord_t;

    // one table entry
    // valid low means the brick was shot away
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   valid;
    } brick_t;

    // whole table, read in parallel by every client
    typedef brick_t [`NUM_BRICKS-1:0] brick_tab_t;

    // one bit per table entry
    typedef logic [`NUM_BRICKS-1:0] brick_mask_t;

    // blocked directions of one mover
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } dir_flags_t;

endpackage : map_pkg

/* hdl/map_top.sv */
`timescale 1ns/100ps

module map_top import map_pkg::*; (
    input  logic       clk_50MHz,
    input  logic       reset,
    // pixel position from the video timing
    input  coord_t     x,
    input  coord_t     y,
    input  logic       refresh_tick,
    input  logic       map_index,
    // player tank edges
    input  coord_t     x_tank_r,
    input  coord_t     x_tank_l,
    input  coord_t     y_tank_t,
    input  coord_t     y_tank_b,
    // enemy tank edges
    input  coord_t     x_enemy_r,
    input  coord_t     x_enemy_l,
    input  coord_t     y_enemy_t,
    input  coord_t     y_enemy_b,
    // player bullet edges
    input  coord_t     x_bullet_r,
    input  coord_t     x_bullet_l,
    input  coord_t     y_bullet_t,
    input  coord_t     y_bullet_b,
    // enemy bullet anchor
    input  coord_t     x_bullet_enemy,
    input  coord_t     y_bullet_enemy,
    output logic       hit,
    output logic       hit_by_enemy,
    output dir_flags_t tank_stop,
    output dir_flags_t enemy_stop,
    output logic       brick_on,
    output logic       wall_on
);

    brick_tab_t  bricks;
    brick_mask_t clear_mask;

    // bundle the plain edge ports
    box_if tank_box ();
    box_if enemy_box ();
    box_if bullet_box ();

    assign tank_box.l   = x_tank_l;
    assign tank_box.r   = x_tank_r;
    assign tank_box.t   = y_tank_t;
    assign tank_box.b   = y_tank_b;
    assign enemy_box.l  = x_enemy_l;
    assign enemy_box.r  = x_enemy_r;
    assign enemy_box.t  = y_enemy_t;
    assign enemy_box.b  = y_enemy_b;
    assign bullet_box.l = x_bullet_l;
    assign bullet_box.r = x_bullet_r;
    assign bullet_box.t = y_bullet_t;
    assign bullet_box.b = y_bullet_b;

    // single writer of the table
    brick_store store_i (
        .clk_50MHz (clk_50MHz),
        .reset     (reset),
        .map_index (map_index),
        .clear_mask(clear_mask),
        .bricks    (bricks)
    );

    bullet_hit hit_i (
        .clk_50MHz     (clk_50MHz),
        .reset         (reset),
        .refresh_tick  (refresh_tick),
        .bricks        (bricks),
        .bullet        (bullet_box.dst),
        .x_bullet_enemy(x_bullet_enemy),
        .y_bullet_enemy(y_bullet_enemy),
        .clear_mask    (clear_mask),
        .hit           (hit),
        .hit_by_enemy  (hit_by_enemy)
    );

    // same blocking test for both tanks
    motion_block tank_block_i (
        .clk_50MHz(clk_50MHz),
        .reset    (reset),
        .bricks   (bricks),
        .mover    (tank_box.dst),
        .stop     (tank_stop)
    );

    motion_block enemy_block_i (
        .clk_50MHz(clk_50MHz),
        .reset    (reset),
        .bricks   (bricks),
        .mover    (enemy_box.dst),
        .stop     (enemy_stop)
    );

    pixel_map pixel_i (
        .clk_50MHz(clk_50MHz),
        .reset    (reset),
        .x        (x),
        .y        (y),
        .bricks   (bricks),
        .brick_on (brick_on),
        .wall_on  (wall_on)
    );

endmodule : map_top

/* hdl/motion_block.sv */
`timescale 1ns/100ps
`include "map_consts.svh"

module motion_block import map_pkg::*; (
    input  logic       clk_50MHz,
    input  logic       reset,
    input  brick_tab_t bricks,
    box_if.dst         mover,
    output dir_flags_t stop
);

    // blocked directions before the register
    dir_flags_t stop_c;

    // sums kept on the mover side so nothing underflows
    always_comb begin
        stop_c = '0;
        for (int i = 0; i < `NUM_BRICKS; i++) begin
            if (bricks[i].valid) begin
                // top edge just under the brick bottom
                if ((mover.t == bricks[i].y + `BRICK_SPAN + `STOP_GAP)
                    && (mover.r <= bricks[i].x + `BRICK_SPAN + `STOP_REACH)
                    && (mover.l + `STOP_REACH >= bricks[i].x))
                    stop_c.up = 1'b1;
                // bottom edge just above the brick top
                if ((mover.b + `STOP_GAP == bricks[i].y)
                    && (mover.r <= bricks[i].x + `BRICK_SPAN + `STOP_REACH)
                    && (mover.l + `STOP_REACH >= bricks[i].x))
                    stop_c.down = 1'b1;
                // left edge just right of the brick
                if ((mover.l == bricks[i].x + `BRICK_SPAN + `STOP_GAP)
                    && (mover.b <= bricks[i].y + `BRICK_SPAN + `STOP_REACH)
                    && (mover.t + `STOP_REACH >= bricks[i].y))
                    stop_c.left = 1'b1;
                // right edge just left of the brick
                if ((mover.r + `STOP_GAP == bricks[i].x)
                    && (mover.b <= bricks[i].y + `BRICK_SPAN + `STOP_REACH)
                    && (mover.t + `STOP_REACH >= bricks[i].y))
                    stop_c.right = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset)
            stop <= '0;
        else
            stop <= stop_c;
    end

endmodule : motion_block

/* hdl/pixel_map.sv */
`timescale 1ns/100ps
`include "map_consts.svh"

module pixel_map import map_pkg::*; (
    input  logic       clk_50MHz,
    input  logic       reset,
    input  coord_t     x,
    input  coord_t     y,
    input  brick_tab_t bricks,
    output logic       brick_on,
    output logic       wall_on
);

    logic brick_hit;
    logic wall_hit;

    // pixel inside any live brick, edges included
    always_comb begin
        brick_hit = 1'b0;
        for (int i = 0; i < `NUM_BRICKS; i++) begin
            if (bricks[i].valid
                && (x >= bricks[i].x) && (x <= bricks[i].x + `BRICK_SPAN)
                && (y >= bricks[i].y) && (y <= bricks[i].y + `BRICK_SPAN))
                brick_hit = 1'b1;
        end
    end

    // wall is everything outside the open play area
    assign wall_hit = !((x > `WALL_L) && (x < `WALL_R) && (y > `WALL_T) && (y < `WALL_B));

    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            brick_on <= 1'b0;
            wall_on  <= 1'b0;
        end else begin
            brick_on <= brick_hit;
            wall_on  <= wall_hit;
        end
    end

endmodule : pixel_map

/* testbench/map_chk.sv */
`timescale 1ns/100ps

module map_chk import map_pkg::*; (
    input logic       clk_50MHz,
    input logic       reset,
    input logic       refresh_tick,
    input logic       hit,
    input logic       hit_by_enemy,
    input dir_flags_t tank_stop,
    input dir_flags_t enemy_stop
);

    // hit pulses last one cycle only
    hit_single: assert property (@(posedge clk_50MHz) disable iff (!reset) hit |=> !hit)
        else $error("hit high for two cycles");
    enemy_hit_single: assert property (@(posedge clk_50MHz) disable iff (!reset)
        hit_by_enemy |=> !hit_by_enemy)
        else $error("hit_by_enemy high for two cycles");

    // a pulse needs a refresh tick the cycle before
    hit_after_tick: assert property (@(posedge clk_50MHz) disable iff (!reset)
        (hit || hit_by_enemy) |-> $past(refresh_tick))
        else $error("hit pulse without a preceding refresh_tick");

    // up and down can never block together
    tank_up_down: assert property (@(posedge clk_50MHz) disable iff (!reset)
        !(tank_stop.up && tank_stop.down))
        else $error("tank_stop shows up and down at once");
    enemy_up_down: assert property (@(posedge clk_50MHz) disable iff (!reset)
        !(enemy_stop.up && enemy_stop.down))
        else $error("enemy_stop shows up and down at once");

endmodule : map_chk

/* testbench/map_tb.sv */
`timescale 1ns/100ps
`include "map_consts.svh"

module map_tb import map_pkg::*; ();

    localparam int clk_period      = 20;
    localparam int num_probes      = 128;
    // map switch is the longest test at two probe sweeps
    localparam int num_tests       = 6;
    localparam int max_test_cycles = 600;
    localparam int margin_cycles   = 200;
    localparam int watchdog_ns     = (num_tests * max_test_cycles + margin_cycles) * clk_period;

    logic       clk_50MHz;
    logic       reset;
    coord_t     x, y;
    logic       refresh_tick;
    logic       map_index;
    coord_t     x_tank_r, x_tank_l, y_tank_t, y_tank_b;
    coord_t     x_enemy_r, x_enemy_l, y_enemy_t, y_enemy_b;
    coord_t     x_bullet_r, x_bullet_l, y_bullet_t, y_bullet_b;
    coord_t     x_bullet_enemy, y_bullet_enemy;
    logic       hit, hit_by_enemy, brick_on, wall_on;
    dir_flags_t tank_stop, enemy_stop;

    // reference copy of the brick table
    int          mod_x [`NUM_BRICKS];
    int          mod_y [`NUM_BRICKS];
    bit          mod_v [`NUM_BRICKS];
    int unsigned lcg_state = 21;
    int          err_count = 0;

    map_top dut_i (.*);

    bind map_top map_chk chk_i (
        .clk_50MHz(clk_50MHz), .reset(reset), .refresh_tick(refresh_tick), .hit(hit),
        .hit_by_enemy(hit_by_enemy), .tank_stop(tank_stop), .enemy_stop(enemy_stop)
    );

    initial clk_50MHz = 1'b0;
    always #(clk_period / 2) clk_50MHz = ~clk_50MHz;

    // probe pixel generator
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    // map 0 is six base columns then field columns
    task automatic build_model(input logic sel);
        int xs [6]    = '{288, 304, 320, 336, 352, 368};
        int ybot [6]  = '{432, 432, 400, 400, 432, 432};
        int cnt [6]   = '{3, 4, 3, 3, 4, 3};
        int col_x [5] = '{96, 240, 544, 112, 256};
        int n;
        n = 0;
        if (!sel) begin
            // base columns stacked upward from their bottom brick
            for (int c = 0; c < 6; c++) begin
                for (int j = 0; j < cnt[c]; j++) begin
                    mod_x[n] = xs[c];
                    mod_y[n] = ybot[c] - `STEP * j;
                    n++;
                end
            end
            // columns of 21 bricks from y 80 down
            for (int k = 0; n < `NUM_BRICKS; k++) begin
                mod_x[n] = col_x[k / 21];
                mod_y[n] = 80 + `STEP * (k % 21);
                n++;
            end
        end else begin
            // map 1 fills rows left to right
            mod_x[0] = `MAP1_X0;
            mod_y[0] = `MAP1_Y0;
            for (int i = 1; i < `NUM_BRICKS; i++) begin
                mod_x[i] = (mod_x[i-1] > `ROW_WRAP) ? `MAP1_X0 : mod_x[i-1] + `STEP;
                mod_y[i] = (mod_x[i-1] > `ROW_WRAP) ? mod_y[i-1] + `ROW_PITCH : mod_y[i-1];
            end
        end
        foreach (mod_v[i]) mod_v[i] = 1'b1;
    endtask

    // pixel on any live brick, edges included
    function automatic bit model_brick_on(input int px, input int py);
        foreach (mod_v[i])
            if (mod_v[i] && px >= mod_x[i] && px <= mod_x[i] + `BRICK_SPAN
                && py >= mod_y[i] && py <= mod_y[i] + `BRICK_SPAN)
                return 1'b1;
        return 1'b0;
    endfunction

    // wall from each inner edge outward
    function automatic bit model_wall_on(input int px, input int py);
        return px <= `WALL_L || px >= `WALL_R || py <= `WALL_T || py >= `WALL_B;
    endfunction

    // box overlap with strict edges
    function automatic bit box_overlaps(input int i, input int l, r, t, b);
        return mod_v[i] && t < mod_y[i] + `BRICK_SPAN && b > mod_y[i]
            && l < mod_x[i] + `BRICK_SPAN && r > mod_x[i];
    endfunction

    // stop flags ORed over all live bricks
    function automatic dir_flags_t model_stop(input int l, r, t, b);
        dir_flags_t f;
        bit         side_x, side_y;
        f = '0;
        foreach (mod_v[i]) begin
            side_x = r <= mod_x[i] + `BRICK_SPAN + `STOP_REACH && l >= mod_x[i] - `STOP_REACH;
            side_y = b <= mod_y[i] + `BRICK_SPAN + `STOP_REACH && t >= mod_y[i] - `STOP_REACH;
            if (mod_v[i] && side_x && t == mod_y[i] + `BRICK_SPAN + `STOP_GAP) f.up = 1'b1;
            if (mod_v[i] && side_x && b == mod_y[i] - `STOP_GAP) f.down = 1'b1;
            if (mod_v[i] && side_y && l == mod_x[i] + `BRICK_SPAN + `STOP_GAP) f.left = 1'b1;
            if (mod_v[i] && side_y && r == mod_x[i] - `STOP_GAP) f.right = 1'b1;
        end
        return f;
    endfunction

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_dir(input string name, input dir_flags_t got, input dir_flags_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // inputs change on the falling edge
    task automatic step();
        @(negedge clk_50MHz);
    endtask

    // whole table in the store against the model
    task automatic check_table();
        for (int i = 0; i < `NUM_BRICKS; i++) begin
            check_coord($sformatf("bricks[%0d].x", i), dut_i.store_i.bricks[i].x,
                        coord_t'(mod_x[i]));
            check_coord($sformatf("bricks[%0d].y", i), dut_i.store_i.bricks[i].y,
                        coord_t'(mod_y[i]));
            check_bit($sformatf("bricks[%0d].valid", i), dut_i.store_i.bricks[i].valid, 1'b1);
        end
    endtask

    // pixel flags are registered so read one cycle later
    task automatic check_pixel(input int px, input int py);
        step();
        x = coord_t'(px);
        y = coord_t'(py);
        step();
        check_bit($sformatf("brick_on at (%0d,%0d)", px, py), brick_on, model_brick_on(px, py));
        check_bit($sformatf("wall_on at (%0d,%0d)", px, py), wall_on, model_wall_on(px, py));
    endtask

    // probes split between the whole screen and the area around a random brick
    task automatic probe_layout();
        int i;
        for (int n = 0; n < num_probes; n++) begin
            i = int'(lcg_next() % `NUM_BRICKS);
            if (lcg_next() % 2)
                check_pixel(int'(lcg_next() % 640), int'(lcg_next() % 480));
            else
                check_pixel(mod_x[i] - 4 + int'(lcg_next() % 24),
                            mod_y[i] - 4 + int'(lcg_next() % 24));
        end
    endtask

    // one shot with hit pulses checked for exactly one cycle
    task automatic shoot(input int l, r, t, b, input int ex, ey, input logic tick);
        bit exp_hit, exp_enemy;
        exp_hit   = 1'b0;
        exp_enemy = 1'b0;
        step();
        {x_bullet_l, x_bullet_r, y_bullet_t, y_bullet_b} = {coord_t'(l), coord_t'(r),
                                                             coord_t'(t), coord_t'(b)};
        x_bullet_enemy = coord_t'(ex);
        y_bullet_enemy = coord_t'(ey);
        refresh_tick   = tick;
        // enemy bullet as its anchor plus the shot span
        foreach (mod_v[i]) begin
            exp_hit   |= tick && box_overlaps(i, l, r, t, b);
            exp_enemy |= tick && box_overlaps(i, ex, ex + `SHOT_SPAN, ey, ey + `SHOT_SPAN);
        end
        // cleared bricks in the model
        foreach (mod_v[i])
            if (tick && (box_overlaps(i, l, r, t, b)
                || box_overlaps(i, ex, ex + `SHOT_SPAN, ey, ey + `SHOT_SPAN)))
                mod_v[i] = 1'b0;
        step();
        refresh_tick = 1'b0;
        check_bit("hit", hit, exp_hit);
        check_bit("hit_by_enemy", hit_by_enemy, exp_enemy);
        step();
        check_bit("hit after pulse", hit, 1'b0);
        check_bit("hit_by_enemy after pulse", hit_by_enemy, 1'b0);
    endtask

    // 32 pixel square mover at stop distance plus off from the brick
    task automatic box_for(input int side, off, bx, by, output int l, r, t, b);
        case (side)
            // under the brick
            0: begin
                t = by + `BRICK_SPAN + `STOP_GAP + off;
                b = t + 31;
                l = bx;
                r = l + 31;
            end
            // above the brick
            1: begin
                b = by - `STOP_GAP - off;
                t = b - 31;
                l = bx;
                r = l + 31;
            end
            // right of the brick
            2: begin
                l = bx + `BRICK_SPAN + `STOP_GAP + off;
                r = l + 31;
                t = by;
                b = t + 31;
            end
            // left of the brick
            default: begin
                r = bx - `STOP_GAP - off;
                l = r - 31;
                t = by;
                b = t + 31;
            end
        endcase
    endtask

    // both movers placed on one side, flags one cycle later
    task automatic block_case(input int side, tank_off, enemy_off, bx, by);
        int tl, tr, tt, tb, el, er, et, eb;
        box_for(side, tank_off, bx, by, tl, tr, tt, tb);
        box_for(side, enemy_off, bx, by, el, er, et, eb);
        step();
        {x_tank_l, x_tank_r, y_tank_t, y_tank_b} = {coord_t'(tl), coord_t'(tr),
                                                     coord_t'(tt), coord_t'(tb)};
        {x_enemy_l, x_enemy_r, y_enemy_t, y_enemy_b} = {coord_t'(el), coord_t'(er),
                                                         coord_t'(et), coord_t'(eb)};
        step();
        check_dir($sformatf("tank_stop side %0d", side), tank_stop, model_stop(tl, tr, tt, tb));
        check_dir($sformatf("enemy_stop side %0d", side), enemy_stop, model_stop(el, er, et, eb));
    endtask

    task automatic test_layout();
        check_table();
        probe_layout();
    endtask

    // each wall edge and the pixel just inside it
    task automatic test_wall();
        int wx [4] = '{`WALL_L, `WALL_L + 1, `WALL_R - 1, `WALL_R};
        int wy [4] = '{`WALL_T, `WALL_T + 1, `WALL_B - 1, `WALL_B};
        for (int i = 0; i < 4; i++) begin
            check_pixel(wx[i], 240);
            check_pixel(320, wy[i]);
        end
        check_pixel(0, 0);
        check_pixel(639, 479);
    endtask

    // brick at (96,80) missed then hit twice
    task automatic test_player_shot();
        shoot(100, 104, 84, 88, 0, 0, 1'b0);
        check_pixel(100, 84);
        shoot(100, 104, 84, 88, 0, 0, 1'b1);
        check_pixel(100, 84);
        shoot(100, 104, 84, 88, 0, 0, 1'b1);
    endtask

    // brick at (96,112) through the enemy bullet
    task automatic test_enemy_shot();
        shoot(0, 0, 0, 0, 100, 116, 1'b0);
        check_pixel(100, 116);
        shoot(0, 0, 0, 0, 100, 116, 1'b1);
        check_pixel(100, 116);
        shoot(0, 0, 0, 0, 100, 116, 1'b1);
    endtask

    // column bottom brick at (96,256) before and after clearing
    task automatic test_blocking();
        for (int side = 0; side < 4; side++) begin
            block_case(side, 0, 1, 96, 256);
            block_case(side, 1, 0, 96, 256);
        end
        shoot(100, 104, 260, 264, 0, 0, 1'b1);
        for (int side = 0; side < 4; side++)
            block_case(side, 0, 0, 96, 256);
    endtask

    task automatic test_map_switch();
        step();
        map_index = 1'b1;
        build_model(1'b1);
        step();
        check_table();
        probe_layout();
        step();
        map_index = 1'b0;
        build_model(1'b0);
        step();
        // shot bricks come back
        check_table();
        check_pixel(100, 84);
        check_pixel(100, 116);
        probe_layout();
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout, tests did not finish within %0d ns", watchdog_ns);
        stop_run();
    end

    initial begin
        reset        = 1'b0;
        refresh_tick = 1'b0;
        map_index    = 1'b0;
        {x, y}       = '0;
        {x_tank_r, x_tank_l, y_tank_t, y_tank_b}         = '0;
        {x_enemy_r, x_enemy_l, y_enemy_t, y_enemy_b}     = '0;
        {x_bullet_r, x_bullet_l, y_bullet_t, y_bullet_b} = '0;
        {x_bullet_enemy, y_bullet_enemy}                 = '0;
        build_model(1'b0);
        // two clock cycles in reset
        repeat (2) @(posedge clk_50MHz);
        @(negedge clk_50MHz);
        reset = 1'b1;
        test_layout();
        test_wall();
        test_player_shot();
        test_enemy_shot();
        test_blocking();
        test_map_switch();
        step();
        if (err_count == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule : map_tb
